/* src/frame_link_pkg.sv */
package frame_link_pkg;

  // ================================================
  // Widths
  // ================================================
  localparam int IMG_IDX_W = 8;
  localparam int ADDR_W    = 23;
  localparam int PIX_W     = 16;
  localparam int COLOR_W   = 10;

  // One 640x480 image per frame-store slot
  localparam logic [ADDR_W-1:0] IMG_BASE  = 23'h100000;
  localparam logic [ADDR_W-1:0] IMG_WORDS = 23'h04B000;
  localparam logic [ADDR_W-1:0] GREY_BASE = '0;

  // ================================================
  // Link and display types
  // ================================================
  typedef struct packed {
    logic [7:0] data;
    logic       valid;
  } rx_beat_t;

  typedef struct packed {
    logic       wr;
    logic [7:0] data;
  } store_wr_t;

  typedef struct packed {
    logic [COLOR_W-1:0] r;
    logic [COLOR_W-1:0] g;
    logic [COLOR_W-1:0] b;
  } rgb_t;

  // Grey level sits in the middle of the sensor word
  typedef struct packed {
    logic [3:0]         unused;
    logic [COLOR_W-1:0] level;
    logic [1:0]         low;
  } grey_view_t;

  typedef struct packed {
    logic [7:0] unused;
    logic [2:0] red;
    logic [2:0] green;
    logic [1:0] blue;
  } rgb332_view_t;

  typedef union packed {
    grey_view_t   grey;
    rgb332_view_t rgb332;
  } pixel_word_u;

  // Active-low segments g..a
  typedef logic [6:0] seg7_t;

endpackage

/* src/uart_receiver.sv */
module uart_receiver
  import frame_link_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic     CLOCK_50,
  input  logic     DLY_RST_0,
  input  logic     rxd,
  output rx_beat_t rx_beat
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_START = 2'd1;
  localparam logic [1:0] S_DATA  = 2'd2;
  localparam logic [1:0] S_STOP  = 2'd3;

  logic [1:0]       rxd_sync;
  logic [1:0]       state;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shift;

  // LSB arrives first, so shift in from the top
  always_ff @(posedge CLOCK_50) begin
    if (state == S_DATA && clk_cnt == BIT_LAST) begin
      shift <= {rxd_sync[1], shift[7:1]};
    end
  end

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      rxd_sync <= 2'b11;
      state    <= S_IDLE;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      rx_beat  <= '0;
    end else begin
      rxd_sync      <= {rxd_sync[0], rxd};
      rx_beat.valid <= 1'b0;
      case (state)
        S_IDLE: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          if (!rxd_sync[1]) begin
            state <= S_START;
          end
        end
        S_START: begin
          // Recheck at mid start bit so glitches fall back to idle
          if (clk_cnt == HALF_LAST) begin
            clk_cnt <= '0;
            state   <= rxd_sync[1] ? S_IDLE : S_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        S_DATA: begin
          if (clk_cnt == BIT_LAST) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= S_STOP;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: begin
          if (clk_cnt == BIT_LAST) begin
            // Framing error drops the byte
            rx_beat.valid <= rxd_sync[1];
            rx_beat.data  <= shift;
            state         <= S_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
      endcase
    end
  end

endmodule

/* src/uart_transmitter.sv */
module uart_transmitter #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic       CLOCK_50,
  input  logic       DLY_RST_0,
  input  logic       start,
  input  logic [7:0] data,
  output logic       txd,
  output logic       busy,
  output logic       done
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

  logic [CNT_W-1:0] clk_cnt;
  logic [3:0]       bit_idx;
  logic [9:0]       frame;

  // Start, data and stop bits go out from bit 0 upward
  always_ff @(posedge CLOCK_50) begin
    if (!busy && start) begin
      frame <= {1'b1, data, 1'b0};
    end else if (busy && clk_cnt == BIT_LAST) begin
      frame <= {1'b1, frame[9:1]};
    end
  end

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      busy    <= 1'b0;
      done    <= 1'b0;
      clk_cnt <= '0;
      bit_idx <= '0;
    end else begin
      done <= 1'b0;
      if (!busy) begin
        clk_cnt <= '0;
        bit_idx <= '0;
        busy    <= start;
      end else if (clk_cnt == BIT_LAST) begin
        clk_cnt <= '0;
        if (bit_idx == 4'd9) begin
          // End of stop bit
          busy <= 1'b0;
          done <= 1'b1;
        end else begin
          bit_idx <= bit_idx + 1'b1;
        end
      end else begin
        clk_cnt <= clk_cnt + 1'b1;
      end
    end
  end

  // Line idles high
  assign txd = busy ? frame[0] : 1'b1;

endmodule

/* src/image_select_regs.sv */
module image_select_regs
  import frame_link_pkg::*;
(
  input  logic                 CLOCK_50,
  input  logic                 DLY_RST_0,
  input  rx_beat_t             rx_beat,
  input  logic                 sw_grey,
  input  logic                 sw_store,
  output store_wr_t            store_wr,
  output logic [IMG_IDX_W-1:0] cur_img,
  output logic                 grey_mode,
  output logic [ADDR_W-1:0]    frame_base_addr,
  output logic                 disp_restart_n
);

  logic [IMG_IDX_W:0]  prev_sel;
  logic                sel_changed;
  logic [ADDR_W-1:0]   img_offset;

  // ================================================
  // Image and store routing
  // ================================================
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      cur_img   <= '0;
      grey_mode <= 1'b0;
      store_wr  <= '0;
    end else begin
      grey_mode     <= sw_grey;
      store_wr.wr   <= rx_beat.valid && sw_store;
      store_wr.data <= rx_beat.data;
      // Store switch on sends the byte to memory and holds the image
      if (rx_beat.valid && !sw_store) begin
        cur_img <= rx_beat.data;
      end
    end
  end

  // ================================================
  // Display restart
  // ================================================
  assign sel_changed = ({cur_img, grey_mode} != prev_sel);

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      prev_sel       <= '0;
      disp_restart_n <= 1'b1;
    end else begin
      prev_sel       <= {cur_img, grey_mode};
      disp_restart_n <= !sel_changed;
    end
  end

  // Grey frames always live at the bottom of the store
  always_comb begin
    img_offset      = IMG_WORDS * ADDR_W'(cur_img);
    frame_base_addr = grey_mode ? GREY_BASE : IMG_BASE + img_offset;
  end

endmodule

/* src/pixel_path.sv */
module pixel_path
  import frame_link_pkg::*;
(
  input  logic        CLOCK_50,
  input  logic        DLY_RST_0,
  input  logic        grey_mode,
  input  pixel_word_u pix_word,
  input  logic        pix_valid,
  output rgb_t        pix_rgb,
  output logic        rgb_valid
);

  rgb_t rgb_next;

  always_comb begin
    if (grey_mode) begin
      rgb_next.r = pix_word.grey.level;
      rgb_next.g = pix_word.grey.level;
      rgb_next.b = pix_word.grey.level;
    end else begin
      // RGB332 bits go to the top of each channel
      rgb_next.r = {pix_word.rgb332.red, {(COLOR_W - 3){1'b0}}};
      rgb_next.g = {pix_word.rgb332.green, {(COLOR_W - 3){1'b0}}};
      rgb_next.b = {pix_word.rgb332.blue, {(COLOR_W - 2){1'b0}}};
    end
  end

  always_ff @(posedge CLOCK_50) begin
    if (pix_valid) begin
      pix_rgb <= rgb_next;
    end
  end

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      rgb_valid <= 1'b0;
    end else begin
      rgb_valid <= pix_valid;
    end
  end

endmodule

/* src/tx_burst.sv */
module tx_burst
  import frame_link_pkg::*;
#(
  parameter int BURST_WORDS = 1024
) (
  input  logic             CLOCK_50,
  input  logic             DLY_RST_0,
  input  logic             key_tx_start_n,
  input  logic             key_tx_abort_n,
  input  logic [PIX_W-1:0] tx_word,
  input  logic             tx_busy,
  input  logic             tx_done,
  output logic             tx_rd,
  output logic             tx_start,
  output logic [7:0]       tx_byte,
  output logic             tx_active
);

  localparam int CNT_W = $clog2(BURST_WORDS + 1);
  localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(BURST_WORDS - 1);

  logic [1:0]       start_sync;
  logic [1:0]       abort_sync;
  logic [CNT_W-1:0] word_cnt;

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      start_sync <= 2'b11;
      abort_sync <= 2'b11;
      tx_active  <= 1'b0;
      word_cnt   <= '0;
    end else begin
      start_sync <= {start_sync[0], key_tx_start_n};
      abort_sync <= {abort_sync[0], key_tx_abort_n};
      // Abort wins over start and lets the byte in flight complete
      if (!abort_sync[1]) begin
        tx_active <= 1'b0;
      end else if (!start_sync[1]) begin
        tx_active <= 1'b1;
        word_cnt  <= '0;
      end else if (tx_done) begin
        word_cnt <= word_cnt + 1'b1;
        if (word_cnt == LAST_WORD) begin
          tx_active <= 1'b0;
        end
      end
    end
  end

  // Done cycle excluded so the last count can stop the burst first
  assign tx_rd    = tx_active && !tx_busy && !tx_done;
  assign tx_start = tx_rd;
  assign tx_byte  = tx_word[7:0];

endmodule

/* src/hex_status.sv */
module hex_status
  import frame_link_pkg::*;
(
  input  logic                 CLOCK_50,
  input  logic                 DLY_RST_0,
  input  rx_beat_t             rx_beat,
  input  logic [IMG_IDX_W-1:0] cur_img,
  input  logic                 tx_active,
  output seg7_t                hex0,
  output seg7_t                hex1,
  output seg7_t                hex2,
  output seg7_t                hex3,
  output seg7_t                hex4,
  output seg7_t                hex5
);

  logic [7:0] last_byte;

  function automatic seg7_t hex_font(input logic [3:0] nib);
    case (nib)
      4'h0: return 7'b1000000;
      4'h1: return 7'b1111001;
      4'h2: return 7'b0100100;
      4'h3: return 7'b0110000;
      4'h4: return 7'b0011001;
      4'h5: return 7'b0010010;
      4'h6: return 7'b0000010;
      4'h7: return 7'b1111000;
      4'h8: return 7'b0000000;
      4'h9: return 7'b0010000;
      4'ha: return 7'b0001000;
      4'hb: return 7'b0000011;
      4'hc: return 7'b1000110;
      4'hd: return 7'b0100001;
      4'he: return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      last_byte <= '0;
    end else if (rx_beat.valid) begin
      last_byte <= rx_beat.data;
    end
  end

  assign hex0 = hex_font(cur_img[3:0]);
  assign hex1 = hex_font(cur_img[7:4]);
  assign hex2 = hex_font(last_byte[3:0]);
  assign hex3 = hex_font(last_byte[7:4]);
  assign hex4 = hex_font({3'b000, tx_active});
  assign hex5 = hex_font(4'h0);

endmodule

/* src/frame_link_top.sv */
module frame_link_top
  import frame_link_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434,
  parameter int BURST_WORDS  = 1024
) (
  input  logic              CLOCK_50,
  input  logic              DLY_RST_0,
  input  logic              uart_rxd,
  input  logic              sw_grey,
  input  logic              sw_store,
  input  logic              key_tx_start_n,
  input  logic              key_tx_abort_n,
  input  logic [PIX_W-1:0]  pix_word,
  input  logic              pix_valid,
  input  logic [PIX_W-1:0]  tx_word,
  output logic              uart_txd,
  output store_wr_t         store_wr,
  output logic [ADDR_W-1:0] frame_base_addr,
  output logic              disp_restart_n,
  output rgb_t              pix_rgb,
  output logic              rgb_valid,
  output logic              tx_rd,
  output seg7_t             hex0,
  output seg7_t             hex1,
  output seg7_t             hex2,
  output seg7_t             hex3,
  output seg7_t             hex4,
  output seg7_t             hex5
);

  rx_beat_t             rx_beat;
  logic [IMG_IDX_W-1:0] cur_img;
  logic                 grey_mode;
  logic                 tx_start;
  logic [7:0]           tx_byte;
  logic                 tx_busy;
  logic                 tx_done;
  logic                 tx_active;

  // ================================================
  // Host link
  // ================================================
  uart_receiver #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_uart_rx (
    .CLOCK_50 (CLOCK_50),
    .DLY_RST_0(DLY_RST_0),
    .rxd      (uart_rxd),
    .rx_beat  (rx_beat)
  );

  uart_transmitter #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_uart_tx (
    .CLOCK_50 (CLOCK_50),
    .DLY_RST_0(DLY_RST_0),
    .start    (tx_start),
    .data     (tx_byte),
    .txd      (uart_txd),
    .busy     (tx_busy),
    .done     (tx_done)
  );

  tx_burst #(
    .BURST_WORDS(BURST_WORDS)
  ) u_tx_burst (
    .CLOCK_50      (CLOCK_50),
    .DLY_RST_0     (DLY_RST_0),
    .key_tx_start_n(key_tx_start_n),
    .key_tx_abort_n(key_tx_abort_n),
    .tx_word       (tx_word),
    .tx_busy       (tx_busy),
    .tx_done       (tx_done),
    .tx_rd         (tx_rd),
    .tx_start      (tx_start),
    .tx_byte       (tx_byte),
    .tx_active     (tx_active)
  );

  // ================================================
  // Display feed and status
  // ================================================
  image_select_regs u_img_sel (
    .CLOCK_50       (CLOCK_50),
    .DLY_RST_0      (DLY_RST_0),
    .rx_beat        (rx_beat),
    .sw_grey        (sw_grey),
    .sw_store       (sw_store),
    .store_wr       (store_wr),
    .cur_img        (cur_img),
    .grey_mode      (grey_mode),
    .frame_base_addr(frame_base_addr),
    .disp_restart_n (disp_restart_n)
  );

  pixel_path u_pixel_path (
    .CLOCK_50 (CLOCK_50),
    .DLY_RST_0(DLY_RST_0),
    .grey_mode(grey_mode),
    .pix_word (pix_word),
    .pix_valid(pix_valid),
    .pix_rgb  (pix_rgb),
    .rgb_valid(rgb_valid)
  );

  hex_status u_hex_status (
    .CLOCK_50 (CLOCK_50),
    .DLY_RST_0(DLY_RST_0),
    .rx_beat  (rx_beat),
    .cur_img  (cur_img),
    .tx_active(tx_active),
    .hex0     (hex0),
    .hex1     (hex1),
    .hex2     (hex2),
    .hex3     (hex3),
    .hex4     (hex4),
    .hex5     (hex5)
  );

endmodule

/* testbench/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ==================================================
// Reference models
// ==================================================
// Active-low segments g..a
function automatic seg7_t digit_segments(input logic [3:0] d);
  case (d)
    4'h0: return 7'b1000000;
    4'h1: return 7'b1111001;
    4'h2: return 7'b0100100;
    4'h3: return 7'b0110000;
    4'h4: return 7'b0011001;
    4'h5: return 7'b0010010;
    4'h6: return 7'b0000010;
    4'h7: return 7'b1111000;
    4'h8: return 7'b0000000;
    4'h9: return 7'b0010000;
    4'ha: return 7'b0001000;
    4'hb: return 7'b0000011;
    4'hc: return 7'b1000110;
    4'hd: return 7'b0100001;
    4'he: return 7'b0000110;
    default: return 7'b0001110;
  endcase
endfunction

function automatic rgb_t expected_rgb(input logic grey, input logic [PIX_W-1:0] w);
  rgb_t c;
  if (grey) begin
    c.r = w[11:2];
    c.g = w[11:2];
    c.b = w[11:2];
  end else begin
    c.r = {w[7:5], 7'b0};
    c.g = {w[4:2], 7'b0};
    c.b = {w[1:0], 8'b0};
  end
  return c;
endfunction

function automatic logic [ADDR_W-1:0] expected_base(input logic grey, input logic [7:0] img);
  logic [31:0] full;
  full = 32'(IMG_BASE) + 32'(IMG_WORDS) * {24'b0, img};
  return grey ? GREY_BASE : full[ADDR_W-1:0];
endfunction

// ==================================================
// Compare tasks
// ==================================================
task automatic report_failure(input string what);
  $display("Check failed: %s", what);
  err_count++;
endtask

task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                          input logic [ADDR_W-1:0] exp);
  if (got !== exp) begin
    $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    err_count++;
  end
endtask

task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
  if (got !== exp) begin
    $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    err_count++;
  end
endtask

task automatic check_store(input string name, input store_wr_t got, input store_wr_t exp);
  if (got !== exp) begin
    $display("[ERROR] %s: got 0x%03h, expected 0x%03h", name, got, exp);
    err_count++;
  end
endtask

task automatic check_seg(input string name, input seg7_t got, input seg7_t exp);
  if (got !== exp) begin
    $display("[ERROR] %s: got 0x%02h, expected 0x%02h", name, got, exp);
    err_count++;
  end
endtask

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
  if (got !== exp) begin
    $display("[ERROR] %s: got 0x%02h, expected 0x%02h", name, got, exp);
    err_count++;
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    err_count++;
  end
endtask

// ==================================================
// Serial line helpers
// ==================================================
// 8N1 frame sent LSB first with CLKS_PER_BIT cycles per bit
task automatic send_serial_byte(input logic [7:0] data);
  logic [9:0] frame;
  frame = {1'b1, data, 1'b0};
  for (int i = 0; i < 10; i++) begin
    uart_rxd = frame[i];
    repeat (CLKS_PER_BIT) @(negedge CLOCK_50);
  end
endtask

task automatic decode_txd_byte(output logic [7:0] data, output logic stop_ok);
  @(negedge CLOCK_50);
  while (uart_txd !== 1'b0) begin
    @(negedge CLOCK_50);
  end
  // Move to the middle of the start bit and then sample once per bit time
  repeat (CLKS_PER_BIT / 2) @(negedge CLOCK_50);
  for (int i = 0; i < 8; i++) begin
    repeat (CLKS_PER_BIT) @(negedge CLOCK_50);
    data[i] = uart_txd;
  end
  repeat (CLKS_PER_BIT) @(negedge CLOCK_50);
  stop_ok = uart_txd;
endtask

`endif

/* testbench/tb_frame_link.sv */
module tb_frame_link
  import frame_link_pkg::*;
;

  localparam int CLKS_PER_BIT = 8;
  localparam int BURST_WORDS  = 4;
  localparam int BYTE_CYCLES  = 10 * CLKS_PER_BIT;
  localparam int PIX_WORDS    = 8;
  // Five times a budget of 50 byte times for all tests
  localparam int TEST_BYTE_TIMES = 50;
  localparam int TIMEOUT_CYCLES  = 5 * TEST_BYTE_TIMES * BYTE_CYCLES;
  localparam logic [31:0] SEED   = 32'h755c_e23a;

  logic              CLOCK_50 = 1'b0;
  logic              DLY_RST_0;
  logic              uart_rxd;
  logic              sw_grey;
  logic              sw_store;
  logic              key_tx_start_n;
  logic              key_tx_abort_n;
  logic [PIX_W-1:0]  pix_word;
  logic              pix_valid;
  logic [PIX_W-1:0]  tx_word;
  logic              uart_txd;
  store_wr_t         store_wr;
  logic [ADDR_W-1:0] frame_base_addr;
  logic              disp_restart_n;
  rgb_t              pix_rgb;
  logic              rgb_valid;
  logic              tx_rd;
  seg7_t             hex0;
  seg7_t             hex1;
  seg7_t             hex2;
  seg7_t             hex3;
  seg7_t             hex4;
  seg7_t             hex5;

  int         err_count     = 0;
  int         test_count    = 0;
  int         fail_count    = 0;
  int         cycle_count   = 0;
  int         restart_count = 0;
  logic [7:0] img_exp       = 8'h00;
  logic [7:0] sent_bytes[$];
  logic [7:0] got_bytes[$];
  store_wr_t  store_seen[$];

  `include "tb_checks.svh"

  frame_link_top #(
    .CLKS_PER_BIT(CLKS_PER_BIT),
    .BURST_WORDS (BURST_WORDS)
  ) dut (
    .CLOCK_50(CLOCK_50), .DLY_RST_0(DLY_RST_0), .uart_rxd(uart_rxd),
    .sw_grey(sw_grey), .sw_store(sw_store), .key_tx_start_n(key_tx_start_n),
    .key_tx_abort_n(key_tx_abort_n), .pix_word(pix_word), .pix_valid(pix_valid),
    .tx_word(tx_word), .uart_txd(uart_txd), .store_wr(store_wr),
    .frame_base_addr(frame_base_addr), .disp_restart_n(disp_restart_n),
    .pix_rgb(pix_rgb), .rgb_valid(rgb_valid), .tx_rd(tx_rd),
    .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5)
  );

  always #5 CLOCK_50 = ~CLOCK_50;

  // ==================================================
  // Monitors and the store model
  // ==================================================
  always @(negedge CLOCK_50) begin
    if (DLY_RST_0 && !disp_restart_n) begin
      restart_count++;
    end
    if (store_wr.wr) begin
      store_seen.push_back(store_wr);
    end
  end

  // Store answers each read in the same cycle
  initial begin
    tx_word = '0;
    forever begin
      @(negedge CLOCK_50);
      if (tx_rd) begin
        tx_word = PIX_W'($urandom);
        sent_bytes.push_back(tx_word[7:0]);
      end
    end
  end

  initial begin
    logic [7:0] b;
    logic       stop_ok;
    forever begin
      decode_txd_byte(b, stop_ok);
      if (!stop_ok) begin
        report_failure("uart_txd stop bit was low");
      end
      got_bytes.push_back(b);
    end
  end

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge CLOCK_50);
      cycle_count++;
    end
    $display("Run stopped: tests still busy after %0d cycles", TIMEOUT_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  // ==================================================
  // Directed tests
  // ==================================================
  task automatic close_test(input string name, input int errs_before);
    test_count++;
    if (err_count == errs_before) begin
      $display("[ok]   %s", name);
    end else begin
      fail_count++;
      $display("[fail] %s, %0d errors", name, err_count - errs_before);
    end
  endtask

  task automatic expect_restart(input int base);
    for (int n = 0; n < 2 * BYTE_CYCLES && restart_count == base; n++) begin
      @(negedge CLOCK_50);
    end
    repeat (4) @(negedge CLOCK_50);
    if (restart_count - base != 1) begin
      report_failure($sformatf("display restart low for %0d cycles, not one",
                               restart_count - base));
    end
  endtask

  task automatic test_reset();
    int errs;
    errs = err_count;
    check_addr("frame_base_addr", frame_base_addr, IMG_BASE);
    check_flag("disp_restart_n", disp_restart_n, 1'b1);
    check_flag("uart_txd", uart_txd, 1'b1);
    check_flag("tx_rd", tx_rd, 1'b0);
    check_flag("rgb_valid", rgb_valid, 1'b0);
    check_flag("store_wr.wr", store_wr.wr, 1'b0);
    check_seg("hex0", hex0, digit_segments(4'h0));
    check_seg("hex1", hex1, digit_segments(4'h0));
    check_seg("hex2", hex2, digit_segments(4'h0));
    check_seg("hex3", hex3, digit_segments(4'h0));
    check_seg("hex4", hex4, digit_segments(4'h0));
    check_seg("hex5", hex5, digit_segments(4'h0));
    close_test("reset state", errs);
  endtask

  task automatic test_image_select();
    int errs;
    int base;
    errs = err_count;
    base = restart_count;
    // Nonzero so the image really changes
    img_exp = 8'($urandom);
    if (img_exp == 8'h00) begin
      img_exp = 8'h3c;
    end
    sw_store = 1'b0;
    send_serial_byte(img_exp);
    expect_restart(base);
    check_addr("frame_base_addr", frame_base_addr, expected_base(1'b0, img_exp));
    check_seg("hex0", hex0, digit_segments(img_exp[3:0]));
    check_seg("hex1", hex1, digit_segments(img_exp[7:4]));
    check_seg("hex2", hex2, digit_segments(img_exp[3:0]));
    check_seg("hex3", hex3, digit_segments(img_exp[7:4]));
    close_test("image select", errs);
  endtask

  task automatic test_store_routing();
    int errs;
    logic [7:0] b;
    errs = err_count;
    b = 8'($urandom);
    // Differs from the image so a wrongly taken byte shows up
    if (b == img_exp) begin
      b = ~img_exp;
    end
    store_seen.delete();
    sw_store = 1'b1;
    send_serial_byte(b);
    for (int n = 0; n < BYTE_CYCLES && store_seen.size() == 0; n++) begin
      @(negedge CLOCK_50);
    end
    repeat (4) @(negedge CLOCK_50);
    if (store_seen.size() != 1) begin
      report_failure($sformatf("%0d store write strobes for one byte", store_seen.size()));
    end else begin
      check_store("store_wr", store_seen[0], '{wr: 1'b1, data: b});
    end
    check_addr("frame_base_addr", frame_base_addr, expected_base(1'b0, img_exp));
    check_seg("hex0", hex0, digit_segments(img_exp[3:0]));
    check_seg("hex1", hex1, digit_segments(img_exp[7:4]));
    sw_store = 1'b0;
    close_test("store routing", errs);
  endtask

  task automatic stream_pixels(input logic grey);
    rgb_t             expect_q[$];
    logic [PIX_W-1:0] w;
    int               seen;
    seen = 0;
    for (int i = 0; i <= PIX_WORDS; i++) begin
      @(negedge CLOCK_50);
      if (rgb_valid && expect_q.size() == 0) begin
        report_failure("rgb_valid high with no pixel in flight");
      end else if (rgb_valid) begin
        check_rgb("pix_rgb", pix_rgb, expect_q.pop_front());
        seen++;
      end
      if (i < PIX_WORDS) begin
        w = PIX_W'($urandom);
        pix_word  = w;
        pix_valid = 1'b1;
        expect_q.push_back(expected_rgb(grey, w));
      end else begin
        pix_valid = 1'b0;
      end
    end
    @(negedge CLOCK_50);
    check_flag("rgb_valid", rgb_valid, 1'b0);
    if (seen != PIX_WORDS) begin
      report_failure($sformatf("%0d of %0d pixels came out", seen, PIX_WORDS));
    end
  endtask

  task automatic test_pixel_decode();
    int errs;
    int base;
    errs = err_count;
    stream_pixels(1'b0);
    base    = restart_count;
    sw_grey = 1'b1;
    expect_restart(base);
    check_addr("frame_base_addr", frame_base_addr, expected_base(1'b1, img_exp));
    stream_pixels(1'b1);
    close_test("pixel decode", errs);
  endtask

  task automatic compare_sent(input int count);
    if (got_bytes.size() != count || sent_bytes.size() != count) begin
      report_failure($sformatf("%0d reads and %0d bytes on uart_txd, expected %0d",
                               sent_bytes.size(), got_bytes.size(), count));
    end
    for (int i = 0; i < count && i < got_bytes.size() && i < sent_bytes.size(); i++) begin
      check_byte("uart_txd byte", got_bytes[i], sent_bytes[i]);
    end
  endtask

  task automatic run_burst(input int bytes, input logic abort);
    sent_bytes.delete();
    got_bytes.delete();
    key_tx_start_n = 1'b0;
    repeat (3) @(negedge CLOCK_50);
    key_tx_start_n = 1'b1;
    for (int n = 0; n < BYTE_CYCLES && sent_bytes.size() == 0; n++) begin
      @(negedge CLOCK_50);
    end
    check_seg("hex4", hex4, digit_segments(4'h1));
    if (abort) begin
      key_tx_abort_n = 1'b0;
      repeat (3) @(negedge CLOCK_50);
      key_tx_abort_n = 1'b1;
    end
    for (int n = 0; n < (bytes + 2) * BYTE_CYCLES && got_bytes.size() < bytes; n++) begin
      @(negedge CLOCK_50);
    end
    for (int n = 0; n < BYTE_CYCLES && hex4 !== digit_segments(4'h0); n++) begin
      @(negedge CLOCK_50);
    end
    check_seg("hex4", hex4, digit_segments(4'h0));
    // Quiet window catches any extra byte
    repeat (3 * BYTE_CYCLES) @(negedge CLOCK_50);
    compare_sent(bytes);
  endtask

  task automatic test_tx_burst();
    int errs;
    errs = err_count;
    run_burst(BURST_WORDS, 1'b0);
    close_test("transmit burst", errs);
  endtask

  task automatic test_tx_abort();
    int errs;
    errs = err_count;
    run_burst(1, 1'b1);
    close_test("transmit abort", errs);
  endtask

  // ==================================================
  // Sequence
  // ==================================================
  initial begin
    void'($urandom(SEED));
    DLY_RST_0      = 1'b0;
    uart_rxd       = 1'b1;
    sw_grey        = 1'b0;
    sw_store       = 1'b0;
    key_tx_start_n = 1'b1;
    key_tx_abort_n = 1'b1;
    pix_word       = '0;
    pix_valid      = 1'b0;
    repeat (8) @(negedge CLOCK_50);
    DLY_RST_0 = 1'b1;
    @(negedge CLOCK_50);
    test_reset();
    test_image_select();
    test_store_routing();
    test_pixel_decode();
    test_tx_burst();
    test_tx_abort();
    $display("tests run %0d, failed %0d, errors %0d", test_count, fail_count, err_count);
    if (err_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+testbench
src/frame_link_pkg.sv
src/uart_receiver.sv
src/uart_transmitter.sv
src/image_select_regs.sv
src/pixel_path.sv
src/tx_burst.sv
src/hex_status.sv
src/frame_link_top.sv
testbench/tb_frame_link.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the frame link testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module tb_frame_link -f sources.f; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_frame_link)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1
